// File: source/memTestPkg.sv
/*
 * Memory tester package.
 * Shared width defaults, the command word from the tester to the
 * SRAM controller and the state encodings of both state machines.
 */
package memTestPkg;

	// **************************************************
	// Default sizes
	// **************************************************
	localparam int cpRamAdrsWidth = 18;	// Word address bits.
	localparam int cpRamDqWidth   = 16;	// Data bus width.
	localparam int cpReadWait     = 2;	// Extra read wait cycles.

	// **************************************************
	// Tester to controller command
	// **************************************************
	typedef struct packed {
		logic        ce;	// One-cycle command strobe.
		logic        write;	// 1 write, 0 read.
		logic [31:0] adrs;	// Low bits carry the word address.
	} memCmd_t;

	// Tester sequencer states.
	typedef enum logic [1:0] {
		testIdle,
		testWrite,
		testRead,
		testFinish
	} testState_e;

	// Controller pin phases.
	typedef enum logic [2:0] {
		sramIdle,
		sramSetup,
		sramStrobe,
		sramWait,
		sramHold
	} sramState_e;

endpackage

// File: source/memTester.sv
`timescale 1ns/1ns
/*
 * Memory tester.
 * Writes an incrementing pattern to every address, then reads each
 * word back and compares it with a second counter. Keeps a sticky
 * error flag and the address of the first failing word, and pulses
 * done once after the last read.
 */
module memTester #(
	parameter int pRamAdrsWidth = memTestPkg::cpRamAdrsWidth,
	parameter int pRamDqWidth   = memTestPkg::cpRamDqWidth
)(
	input  logic                     iCLK,
	input  logic                     iRST,
	input  logic                     start,
	output memTestPkg::memCmd_t      cmd,
	output logic [pRamDqWidth-1:0]   wd,
	input  logic                     wEd,
	input  logic                     rEd,
	input  logic [pRamDqWidth-1:0]   rd,
	output logic                     done,
	output logic                     err,
	output logic [pRamAdrsWidth-1:0] errAdrs
);
	import memTestPkg::*;

	testState_e               rState;
	logic [pRamAdrsWidth-1:0] rAdrs;
	logic [pRamDqWidth-1:0]   rWd;		// Write pattern.
	logic [pRamDqWidth-1:0]   rComp;	// Expected read word.
	logic                     rCe;
	logic                     rWrite;
	logic                     rPend;	// Access in flight.
	logic                     rErr;
	logic [pRamAdrsWidth-1:0] rErrAdrs;
	logic                     qMaxAdrs;
	logic                     qMiss;

	assign qMaxAdrs = (rAdrs == {pRamAdrsWidth{1'b1}});
	assign qMiss    = rEd & (rd != rComp) & (rState == testRead);

	// **************************************************
	// Sequencer
	// **************************************************
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			rState <= testIdle;
			rCe    <= 1'b0;
			rWrite <= 1'b0;
			rPend  <= 1'b0;
			rErr   <= 1'b0;
		end
		else
		begin
			rCe <= 1'b0;			// Strobe lasts one cycle.

			if (rCe)
				rPend <= 1'b1;
			else if (wEd | rEd)
				rPend <= 1'b0;

			case (rState)
				testIdle:
				begin
					if (start)
					begin
						rState <= testWrite;
						rCe    <= 1'b1;
						rWrite <= 1'b1;
						rErr   <= 1'b0;	// Cleared on every start.
					end
				end

				testWrite:
				begin
					if (wEd)
					begin
						rCe <= 1'b1;	// Next write, or first read.
						if (qMaxAdrs)
						begin
							rState <= testRead;
							rWrite <= 1'b0;
						end
					end
				end

				testRead:
				begin
					if (rEd)
					begin
						if (qMiss)
							rErr <= 1'b1;
						if (qMaxAdrs)
							rState <= testFinish;
						else
							rCe <= 1'b1;
					end
				end

				testFinish:
					rState <= testIdle;

				default:
					rState <= testIdle;
			endcase
		end
	end

	// **************************************************
	// Address, pattern and compare counters
	// **************************************************
	always_ff @(posedge iCLK)
	begin
		case (rState)
			testIdle:
			begin
				if (start)
				begin
					rAdrs    <= '0;
					rWd      <= '0;
					rComp    <= '0;
					rErrAdrs <= '0;
				end
			end

			testWrite:
			begin
				if (wEd)
				begin
					rAdrs <= rAdrs + 1'b1;	// Wraps to zero for the read pass.
					rWd   <= rWd + 1'b1;
				end
			end

			testRead:
			begin
				if (rEd)
				begin
					rAdrs <= rAdrs + 1'b1;
					rComp <= rComp + 1'b1;
					if (qMiss & ~rErr)
						rErrAdrs <= rAdrs;	// First failure only.
				end
			end

			default:
			begin
			end
		endcase
	end

	always_comb
	begin
		cmd.ce    = rCe;
		cmd.write = rWrite;
		cmd.adrs  = {{(32 - pRamAdrsWidth){1'b0}}, rAdrs};
	end

	assign wd      = rWd;
	assign done    = (rState == testFinish);
	assign err     = rErr;
	assign errAdrs = rErrAdrs;

	// No new command until the controller has answered the last one.
	assert property (@(posedge iCLK) disable iff (iRST) cmd.ce |-> !rPend)
		else $error("memTester: command issued with an access outstanding");

endmodule

// File: source/sramController.sv
`timescale 1ns/1ns
/*
 * Asynchronous SRAM controller.
 * Turns one-cycle commands into setup, strobe and hold phases on the
 * SRAM pins. Reads wait a programmable number of cycles before the
 * data is registered; each access ends with a wEd or rEd pulse.
 */
module sramController #(
	parameter int pRamAdrsWidth = memTestPkg::cpRamAdrsWidth,
	parameter int pRamDqWidth   = memTestPkg::cpRamDqWidth,
	parameter int pReadWait     = memTestPkg::cpReadWait
)(
	input  logic                     iCLK,
	input  logic                     iRST,
	input  memTestPkg::memCmd_t      cmd,
	input  logic [pRamDqWidth-1:0]   wd,
	output logic                     wEd,
	output logic                     rEd,
	output logic [pRamDqWidth-1:0]   rd,
	output logic [pRamAdrsWidth-1:0] sramAdrs,
	output logic [pRamDqWidth-1:0]   sramDqOut,
	input  logic [pRamDqWidth-1:0]   sramDqIn,
	output logic                     sramCeN,
	output logic                     sramWeN,
	output logic                     sramOeN
);
	import memTestPkg::*;

	localparam int lpWaitWidth = (pReadWait > 0) ? $clog2(pReadWait + 1) : 1;

	sramState_e               rState;
	logic                     rWrite;
	logic [lpWaitWidth-1:0]   rWaitCnt;
	logic                     rCeN, rWeN, rOeN;
	logic                     rWEd, rREd;
	logic [pRamAdrsWidth-1:0] rAdrs;
	logic [pRamDqWidth-1:0]   rDqOut;
	logic [pRamDqWidth-1:0]   rRd;
	logic                     qWaitEnd;

	assign qWaitEnd = (rWaitCnt == lpWaitWidth'(pReadWait));

	// **************************************************
	// Pin phase state machine
	// **************************************************
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			rState   <= sramIdle;
			rWrite   <= 1'b0;
			rWaitCnt <= '0;
			rCeN     <= 1'b1;
			rWeN     <= 1'b1;
			rOeN     <= 1'b1;
			rWEd     <= 1'b0;
			rREd     <= 1'b0;
		end
		else
		begin
			case (rState)
				sramIdle:
				begin
					rREd <= 1'b0;
					if (cmd.ce)
					begin
						rState <= sramSetup;
						rWrite <= cmd.write;
						rCeN   <= 1'b0;
						rOeN   <= cmd.write;	// Output enable for reads only.
					end
				end

				sramSetup:
				begin
					if (rWrite)
					begin
						rWeN   <= 1'b0;
						rState <= sramStrobe;
					end
					else
					begin
						rWaitCnt <= '0;
						rState   <= sramWait;
					end
				end

				sramStrobe:
				begin
					rWeN   <= 1'b1;			// Data latched on the rising edge.
					rWEd   <= 1'b1;
					rState <= sramHold;
				end

				sramHold:
				begin
					rWEd   <= 1'b0;
					rCeN   <= 1'b1;
					rState <= sramIdle;
				end

				sramWait:
				begin
					if (qWaitEnd)
					begin
						rREd   <= 1'b1;
						rOeN   <= 1'b1;
						rCeN   <= 1'b1;
						rState <= sramIdle;
					end
					else
						rWaitCnt <= rWaitCnt + 1'b1;
				end

				default:
					rState <= sramIdle;
			endcase
		end
	end

	// Address, write data and read capture.
	always_ff @(posedge iCLK)
	begin
		if (rState == sramIdle && cmd.ce)
		begin
			rAdrs  <= cmd.adrs[pRamAdrsWidth-1:0];
			rDqOut <= wd;
		end
		if (rState == sramWait && qWaitEnd)
			rRd <= sramDqIn;
	end

	assign sramAdrs  = rAdrs;
	assign sramDqOut = rDqOut;
	assign sramCeN   = rCeN;
	assign sramWeN   = rWeN;
	assign sramOeN   = rOeN;
	assign wEd       = rWEd;
	assign rEd       = rREd;
	assign rd        = rRd;

	// Bus contention on the SRAM data pins.
	assert property (@(posedge iCLK) disable iff (iRST) !(!sramWeN && !sramOeN))
		else $error("sramController: WE and OE low together");

	// A write strobe is one cycle wide and sits inside chip enable.
	assert property (@(posedge iCLK) disable iff (iRST)
		$fell(sramWeN) |-> !sramCeN ##1 (sramWeN && !sramCeN))
		else $error("sramController: malformed write strobe");

endmodule

// File: source/memTestTop.sv
`timescale 1ns/1ns
/*
 * Memory test top level.
 * Connects the tester to the SRAM controller and brings out the
 * SRAM pins and the test status.
 */
module memTestTop #(
	parameter int pRamAdrsWidth = memTestPkg::cpRamAdrsWidth,
	parameter int pRamDqWidth   = memTestPkg::cpRamDqWidth,
	parameter int pReadWait     = memTestPkg::cpReadWait
)(
	input  logic                     iCLK,
	input  logic                     iRST,
	input  logic                     start,
	output logic                     done,
	output logic                     err,
	output logic [pRamAdrsWidth-1:0] errAdrs,
	// SRAM pins.
	output logic [pRamAdrsWidth-1:0] sramAdrs,
	output logic [pRamDqWidth-1:0]   sramDqOut,
	input  logic [pRamDqWidth-1:0]   sramDqIn,
	output logic                     sramCeN,
	output logic                     sramWeN,
	output logic                     sramOeN
);
	import memTestPkg::*;

	memCmd_t                cmd;
	logic [pRamDqWidth-1:0] wd;
	logic [pRamDqWidth-1:0] rd;
	logic                   wEd;
	logic                   rEd;

	// **************************************************
	// Pattern sequencer
	// **************************************************
	memTester #(
		.pRamAdrsWidth (pRamAdrsWidth),
		.pRamDqWidth   (pRamDqWidth)
	) u_memTester (
		.iCLK    (iCLK),
		.iRST    (iRST),
		.start   (start),
		.cmd     (cmd),
		.wd      (wd),
		.wEd     (wEd),
		.rEd     (rEd),
		.rd      (rd),
		.done    (done),
		.err     (err),
		.errAdrs (errAdrs)
	);

	// **************************************************
	// SRAM pin timing
	// **************************************************
	sramController #(
		.pRamAdrsWidth (pRamAdrsWidth),
		.pRamDqWidth   (pRamDqWidth),
		.pReadWait     (pReadWait)
	) u_sramController (
		.iCLK      (iCLK),
		.iRST      (iRST),
		.cmd       (cmd),
		.wd        (wd),
		.wEd       (wEd),
		.rEd       (rEd),
		.rd        (rd),
		.sramAdrs  (sramAdrs),
		.sramDqOut (sramDqOut),
		.sramDqIn  (sramDqIn),
		.sramCeN   (sramCeN),
		.sramWeN   (sramWeN),
		.sramOeN   (sramOeN)
	);

endmodule

// File: sim/sramModel.sv
`timescale 1ns/1ns
/*
 * Behavioral asynchronous SRAM.
 * Stores a word on the rising edge of WE while CE is low and drives
 * the read data while CE and OE are both low. The word at one address
 * can be corrupted on its way out with an XOR mask.
 */
module sramModel #(
	parameter int pAdrsWidth = 6,
	parameter int pDqWidth   = 16
)(
	input  logic [pAdrsWidth-1:0] adrs,
	input  logic [pDqWidth-1:0]   dIn,
	output logic [pDqWidth-1:0]   dOut,
	input  logic                  ceN,
	input  logic                  weN,
	input  logic                  oeN,
	input  logic [pAdrsWidth-1:0] faultAdrs,
	input  logic [pDqWidth-1:0]   faultMask
);
	logic [pDqWidth-1:0] memArray [0:(1 << pAdrsWidth)-1];
	logic [pDqWidth-1:0] qFlip;

	// Stored words stay clean, the fault only shows on reads.
	assign qFlip = (adrs == faultAdrs) ? faultMask : '0;
	assign dOut  = (!ceN && !oeN) ? (memArray[adrs] ^ qFlip) : '0;

	// Data latched when WE goes back high.
	always @(posedge weN)
	begin
		if (!ceN)
			memArray[adrs] <= dIn;
	end

endmodule

// File: sim/tbMemTest.sv
`timescale 1ns/1ns
/*
 * Memory tester testbench.
 * Runs one test pass per line of the case file with a fault injected
 * in the SRAM model, then checks the status outputs, the stored
 * pattern and the CE, WE and OE strobe counts of each pass.
 */
module tbMemTest;

	localparam int lpAdrsWidth = 6;
	localparam int lpDqWidth   = 16;
	localparam int lpReadWait  = 2;
	localparam int lpWords     = 1 << lpAdrsWidth;
	localparam int lpMaxCases  = 16;
	localparam int lpTimeout   = 4000;	// About six times one pass.

	logic                   iCLK;
	logic                   iRST;
	logic                   start;
	logic                   done;
	logic                   err;
	logic [lpAdrsWidth-1:0] errAdrs;
	logic [lpAdrsWidth-1:0] sramAdrs;
	logic [lpDqWidth-1:0]   sramDqOut;
	logic [lpDqWidth-1:0]   sramDqIn;
	logic                   sramCeN;
	logic                   sramWeN;
	logic                   sramOeN;
	logic [lpAdrsWidth-1:0] faultAdrs;
	logic [lpDqWidth-1:0]   faultMask;
	logic [15:0]            caseData [0:3*lpMaxCases-1];
	logic                   prevCeN;
	logic                   prevWeN;
	logic                   prevOeN;
	int                     ceCount;
	int                     weCount;
	int                     oeCount;
	int                     overlapCount;
	int                     errCount;
	int                     testCount;
	int                     passCount;
	int                     failCount;
	bit                     timedOut;

	memTestTop #(
		.pRamAdrsWidth (lpAdrsWidth),
		.pRamDqWidth   (lpDqWidth),
		.pReadWait     (lpReadWait)
	) u_memTestTop (
		.iCLK      (iCLK),
		.iRST      (iRST),
		.start     (start),
		.done      (done),
		.err       (err),
		.errAdrs   (errAdrs),
		.sramAdrs  (sramAdrs),
		.sramDqOut (sramDqOut),
		.sramDqIn  (sramDqIn),
		.sramCeN   (sramCeN),
		.sramWeN   (sramWeN),
		.sramOeN   (sramOeN)
	);

	sramModel #(
		.pAdrsWidth (lpAdrsWidth),
		.pDqWidth   (lpDqWidth)
	) u_sramModel (
		.adrs      (sramAdrs),
		.dIn       (sramDqOut),
		.dOut      (sramDqIn),
		.ceN       (sramCeN),
		.weN       (sramWeN),
		.oeN       (sramOeN),
		.faultAdrs (faultAdrs),
		.faultMask (faultMask)
	);

	always #2 iCLK = ~iCLK;

	// **************************************************
	// Strobe counters, cleared by start
	// **************************************************
	always @(posedge iCLK)
	begin
		if (iRST || start)
		begin
			ceCount      <= 0;
			weCount      <= 0;
			oeCount      <= 0;
			overlapCount <= 0;
		end
		else
		begin
			if (prevCeN && !sramCeN)
				ceCount <= ceCount + 1;		// One chip enable per access.
			if (prevWeN && !sramWeN)
				weCount <= weCount + 1;		// Falling edge of WE.
			if (prevOeN && !sramOeN)
				oeCount <= oeCount + 1;
			if (!sramWeN && !sramOeN)
				overlapCount <= overlapCount + 1;
		end
		prevCeN <= sramCeN;
		prevWeN <= sramWeN;
		prevOeN <= sramOeN;
	end

	// Polls done once per cycle.
	task automatic waitDone(output bit ok);
		int cycles;
		cycles = 0;
		while (!done && cycles < lpTimeout)
		begin
			@(posedge iCLK);
			#1;
			cycles++;
		end
		ok = done;
	endtask

	// Every stored word must equal its own address.
	task automatic checkStoredPattern(input int idx);
		int i;
		for (i = 0; i < lpWords; i++)
		begin
			if (u_sramModel.memArray[i] !== lpDqWidth'(i))
			begin
				$display("MISMATCH test %0d memArray[%0d] got 0x%0h expected 0x%0h",
					idx, i, u_sramModel.memArray[i], lpDqWidth'(i));
				errCount++;
			end
		end
	endtask

	task automatic runCase(input int idx, input logic [15:0] fAdrs,
		input logic [15:0] fMask, input logic [15:0] expAdrs);
		int   errBefore;
		bit   ok;
		logic expErr;
		errBefore = errCount;
		expErr    = (fMask != 16'h0);
		faultAdrs = fAdrs[lpAdrsWidth-1:0];
		faultMask = fMask;

		start = 1'b1;
		@(posedge iCLK);
		#1;
		start = 1'b0;
		if (err !== 1'b0)
		begin
			$display("MISMATCH test %0d err after start got 0x%0h expected 0x0", idx, err);
			errCount++;
		end

		waitDone(ok);
		if (!ok)
		begin
			$display("ERROR test %0d: done never arrived within %0d cycles", idx, lpTimeout);
			errCount++;
			timedOut = 1'b1;
		end
		else
		begin
			if (err !== expErr)
			begin
				$display("MISMATCH test %0d err got 0x%0h expected 0x%0h", idx, err, expErr);
				errCount++;
			end
			if (expErr && errAdrs !== expAdrs[lpAdrsWidth-1:0])
			begin
				$display("MISMATCH test %0d errAdrs got 0x%0h expected 0x%0h",
					idx, errAdrs, expAdrs[lpAdrsWidth-1:0]);
				errCount++;
			end
			checkStoredPattern(idx);
			if (ceCount != 2 * lpWords)
			begin
				$display("MISMATCH test %0d ceCount got 0x%0h expected 0x%0h",
					idx, ceCount, 2 * lpWords);
				errCount++;
			end
			if (weCount != lpWords)
			begin
				$display("MISMATCH test %0d weCount got 0x%0h expected 0x%0h",
					idx, weCount, lpWords);
				errCount++;
			end
			if (oeCount != lpWords)
			begin
				$display("MISMATCH test %0d oeCount got 0x%0h expected 0x%0h",
					idx, oeCount, lpWords);
				errCount++;
			end
			if (overlapCount != 0)
			begin
				$display("ERROR test %0d: WE and OE were low together in %0d cycles",
					idx, overlapCount);
				errCount++;
			end
		end

		testCount++;
		if (errCount == errBefore)
		begin
			passCount++;
			$display("Test %0d fault adrs 0x%0h mask 0x%0h: ok", idx, fAdrs, fMask);
		end
		else
		begin
			failCount++;
			$display("Test %0d fault adrs 0x%0h mask 0x%0h: FAILED with %0d errors",
				idx, fAdrs, fMask, errCount - errBefore);
		end
		@(posedge iCLK);	// Tester back in IDLE.
		#1;
	endtask

	// **************************************************
	// Main sequence
	// **************************************************
	initial
	begin
		int k;
		iCLK      = 1'b0;
		iRST      = 1'b1;
		start     = 1'b0;
		faultAdrs = '0;
		faultMask = '0;
		errCount  = 0;
		testCount = 0;
		passCount = 0;
		failCount = 0;
		timedOut  = 1'b0;
		for (k = 0; k < 3 * lpMaxCases; k++)
			caseData[k] = 16'hffff;		// End marker where no case is loaded.
		$readmemh("sim/memtest_input.txt", caseData);

		repeat (16) @(posedge iCLK);
		#1;
		iRST = 1'b0;
		@(posedge iCLK);
		#1;

		k = 0;
		while (k < lpMaxCases && caseData[3*k] != 16'hffff && !timedOut)
		begin
			runCase(k, caseData[3*k], caseData[3*k+1], caseData[3*k+2]);
			k++;
		end
		if (testCount == 0)
		begin
			$display("ERROR: no test cases were read from the case file");
			errCount++;
		end

		$display("Tests %0d, passed %0d, failed %0d, errors %0d",
			testCount, passCount, failCount, errCount);
		if (errCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: sim/memtest_input.txt
// Columns: fault address, fault XOR mask, expected first-error address (hex).
// A zero mask is a clean pass where err must stay low.
0000 0000 0000
0005 0001 0005
0000 8000 0000
0000 0000 0000
003f ffff 003f
0021 00f0 0021
0000 0000 0000

// File: compile.f
source/memTestPkg.sv
source/memTester.sv
source/sramController.sv
source/memTestTop.sv
sim/sramModel.sv
sim/tbMemTest.sv

// File: run.sh
#!/bin/sh
# Builds the memory tester testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tbMemTest \
	-Mdir obj_dir -o simMemTest
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simMemTest > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
exit 0
